//--- design/pmp_apb_csr.sv
`timescale 1ns/100ps
`include "pmp_macros.svh"

module pmp_apb_csr (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`PMP_CSR_AW-1:0]   paddr,
  input  logic [`PMP_XLEN-1:0]     pwdata,
  output logic [`PMP_XLEN-1:0]     prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     cfg_wr_en,
  output logic                     cfg_wr_word,
  output logic                     addr_wr_en,
  output logic [`PMP_IDX_W-1:0]    addr_wr_idx,
  output logic [`PMP_XLEN-1:0]     wr_data,
  output logic                     rd_sel_cfg,
  output logic [`PMP_IDX_W-1:0]    rd_idx,
  input  logic [`PMP_XLEN-1:0]     rd_data
);

  logic                   setup_phase;
  logic                   access_phase;
  logic [`PMP_CSR_AW-1:0] cfg_off;
  logic [`PMP_CSR_AW-1:0] addr_off;
  logic                   cfg_hit;
  logic                   addr_hit;
  logic                   mapped;

  assign setup_phase  = psel & ~penable;
  assign access_phase = psel & penable;

  // Offsets wrap below the base, so one unsigned compare covers both ends
  assign cfg_off  = paddr - `PMP_CFG_BASE;
  assign addr_off = paddr - `PMP_ADDR_BASE;
  assign cfg_hit  = cfg_off < `PMP_CSR_AW'(`PMP_CFG_WORDS);
  assign addr_hit = addr_off < `PMP_CSR_AW'(`PMP_REGIONS);
  assign mapped   = cfg_hit | addr_hit;

  // Write strobes only pulse in the access phase of a mapped write
  assign cfg_wr_en   = access_phase & pwrite & cfg_hit;
  assign cfg_wr_word = cfg_off[0];
  assign addr_wr_en  = access_phase & pwrite & addr_hit;
  assign addr_wr_idx = addr_off[`PMP_IDX_W-1:0];
  assign wr_data     = pwdata;

  // For a cfg read only the word number matters
  assign rd_sel_cfg = cfg_hit;
  assign rd_idx     = cfg_hit ? `PMP_IDX_W'(cfg_off[0]) : addr_off[`PMP_IDX_W-1:0];

  assign prdata = (access_phase && !pwrite && mapped) ? rd_data : '0;

  // The address is stable from setup to access, so the response is decided one cycle early
  always_ff @(posedge clock) begin
    if (!reset) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= setup_phase;
      pslverr <= setup_phase & ~mapped;
    end
  end

endmodule

//--- design/pmp_checker.sv
`timescale 1ns/100ps
`include "pmp_macros.svh"

module pmp_checker
  import pmp_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   chk_valid,
  input  logic [`PMP_XLEN-1:0]   chk_addr,
  input  priv_t                  chk_priv,
  input  access_t                chk_kind,
  input  pmp_cfg_t               cfg_q [0:`PMP_REGIONS-1],
  input  logic [`PMP_XLEN-1:0]   addr_q [0:`PMP_REGIONS-1],
  output logic                   rsp_valid,
  output logic                   rsp_fault
);

  logic [`PMP_XLEN-1:0]    word_addr;
  logic [`PMP_REGIONS-1:0] region_match;
  logic [`PMP_REGIONS-1:0] region_allow;
  logic                    allow;

  // pmpaddr holds bits 33:2 of the range, so compare in word units
  assign word_addr = {2'b00, chk_addr[`PMP_XLEN-1:2]};

  for (genvar i = 0; i < `PMP_REGIONS; i++) begin : g_region
    logic [`PMP_XLEN-1:0] lower;
    logic [`PMP_XLEN-1:0] napot_mask;
    logic                 match_here;
    logic                 perm;

    if (i == 0) begin : g_first
      assign lower = '0;
    end else begin : g_next
      assign lower = addr_q[i-1];
    end

    // Trailing ones plus the first zero give the don't-care bits of a NAPOT range
    assign napot_mask = addr_q[i] ^ (addr_q[i] + 1'b1);

    always_comb begin
      case (cfg_q[i].match)
        tor:     match_here = (word_addr >= lower) && (word_addr < addr_q[i]);
        na4:     match_here = (word_addr == addr_q[i]);
        napot:   match_here = ((word_addr ^ addr_q[i]) & ~napot_mask) == '0;
        default: match_here = 1'b0;
      endcase
    end

    always_comb begin
      case (chk_kind)
        exec:    perm = cfg_q[i].x;
        read:    perm = cfg_q[i].r;
        write:   perm = cfg_q[i].w;
        default: perm = 1'b0;
      endcase
    end

    assign region_match[i] = match_here;
    // Machine mode bypasses an unlocked region
    assign region_allow[i] = perm | ((chk_priv == machine) & ~cfg_q[i].lock);
  end

  // Walking downward leaves the lowest matching region in charge
  always_comb begin
    allow = (chk_priv == machine);  // No match at all
    for (int i = `PMP_REGIONS - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        allow = region_allow[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rsp_valid <= 1'b0;
      rsp_fault <= 1'b0;
    end else begin
      rsp_valid <= chk_valid;
      rsp_fault <= chk_valid & ~allow;
    end
  end

endmodule

//--- design/pmp_macros.svh
`ifndef PMP_MACROS_SVH
`define PMP_MACROS_SVH

// Region count and the index width that addresses one region
`define PMP_REGIONS 8
`define PMP_IDX_W 3

// Four cfg bytes are packed into each pmpcfg word
`define PMP_CFG_WORDS (`PMP_REGIONS / 4)

// CSR map as seen on the APB side
`define PMP_CSR_AW 12
`define PMP_CFG_BASE 12'h3A0
`define PMP_ADDR_BASE 12'h3B0

// RV32 register and access address width
`define PMP_XLEN 32

`endif

//--- design/pmp_pkg.sv
package pmp_pkg;

  // Address matching mode, encoded as the A field of a pmpcfg byte
  typedef enum logic [1:0] {
    off   = 2'd0,
    tor   = 2'd1,
    na4   = 2'd2,
    napot = 2'd3
  } pmp_match_t;

  // One pmpcfg byte, most significant field first
  typedef struct packed {
    logic       lock;
    logic [1:0] rsvd;  // Always stored as zero
    pmp_match_t match;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

  typedef enum logic {
    user    = 1'b0,
    machine = 1'b1
  } priv_t;

  typedef enum logic [1:0] {
    exec  = 2'd0,
    read  = 2'd1,
    write = 2'd2
  } access_t;

endpackage

//--- design/pmp_region_file.sv
`timescale 1ns/100ps
`include "pmp_macros.svh"

module pmp_region_file
  import pmp_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   cfg_wr_en,
  input  logic                   cfg_wr_word,
  input  logic                   addr_wr_en,
  input  logic [`PMP_IDX_W-1:0]  addr_wr_idx,
  input  logic [`PMP_XLEN-1:0]   wr_data,
  input  logic                   rd_sel_cfg,
  input  logic [`PMP_IDX_W-1:0]  rd_idx,
  output logic [`PMP_XLEN-1:0]   rd_data,
  output pmp_cfg_t               cfg_q [0:`PMP_REGIONS-1],
  output logic [`PMP_XLEN-1:0]   addr_q [0:`PMP_REGIONS-1]
);

  logic [`PMP_REGIONS-1:0] addr_locked;

  function automatic pmp_cfg_t cfg_from_byte(input logic [7:0] b);
    pmp_cfg_t cfg_byte;
    cfg_byte      = pmp_cfg_t'(b);
    cfg_byte.rsvd = 2'b00;
    return cfg_byte;
  endfunction

  // An addr register is frozen by its own lock or by a locked TOR region above it
  for (genvar i = 0; i < `PMP_REGIONS; i++) begin : g_addr_lock
    if (i == `PMP_REGIONS - 1) begin : g_last
      assign addr_locked[i] = cfg_q[i].lock;
    end else begin : g_inner
      assign addr_locked[i] = cfg_q[i].lock |
                              (cfg_q[i+1].lock & (cfg_q[i+1].match == tor));
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `PMP_REGIONS; i++) begin
        cfg_q[i]  <= '0;
        addr_q[i] <= '0;
      end
    end else begin
      // Each byte of a cfg word write is kept or dropped on its own lock bit
      for (int i = 0; i < `PMP_REGIONS; i++) begin
        if (cfg_wr_en && (i / 4 == int'(cfg_wr_word)) && !cfg_q[i].lock) begin
          cfg_q[i] <= cfg_from_byte(wr_data[8*(i%4) +: 8]);
        end
      end
      if (addr_wr_en && !addr_locked[addr_wr_idx]) begin
        addr_q[addr_wr_idx] <= wr_data;  // Locked targets ignore the write quietly
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (rd_sel_cfg) begin
      for (int b = 0; b < 4; b++) begin
        rd_data[8*b +: 8] = cfg_q[4*int'(rd_idx[0]) + b];
      end
    end else begin
      rd_data = addr_q[rd_idx];
    end
  end

endmodule

//--- design/pmp_top.sv
`timescale 1ns/100ps
`include "pmp_macros.svh"

module pmp_top
  import pmp_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`PMP_CSR_AW-1:0]   paddr,
  input  logic [`PMP_XLEN-1:0]     pwdata,
  output logic [`PMP_XLEN-1:0]     prdata,
  output logic                     pready,
  output logic                     pslverr,
  input  logic                     chk_valid,
  input  logic [`PMP_XLEN-1:0]     chk_addr,
  input  priv_t                    chk_priv,
  input  access_t                  chk_kind,
  output logic                     rsp_valid,
  output logic                     rsp_fault
);

  logic                  cfg_wr_en;
  logic                  cfg_wr_word;
  logic                  addr_wr_en;
  logic [`PMP_IDX_W-1:0] addr_wr_idx;
  logic [`PMP_XLEN-1:0]  wr_data;
  logic                  rd_sel_cfg;
  logic [`PMP_IDX_W-1:0] rd_idx;
  logic [`PMP_XLEN-1:0]  rd_data;
  pmp_cfg_t              cfg_q [0:`PMP_REGIONS-1];
  logic [`PMP_XLEN-1:0]  addr_q [0:`PMP_REGIONS-1];

  pmp_apb_csr i_apb_csr (
    .clock       (clock),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .cfg_wr_en   (cfg_wr_en),
    .cfg_wr_word (cfg_wr_word),
    .addr_wr_en  (addr_wr_en),
    .addr_wr_idx (addr_wr_idx),
    .wr_data     (wr_data),
    .rd_sel_cfg  (rd_sel_cfg),
    .rd_idx      (rd_idx),
    .rd_data     (rd_data)
  );

  pmp_region_file i_region_file (
    .clock       (clock),
    .reset       (reset),
    .cfg_wr_en   (cfg_wr_en),
    .cfg_wr_word (cfg_wr_word),
    .addr_wr_en  (addr_wr_en),
    .addr_wr_idx (addr_wr_idx),
    .wr_data     (wr_data),
    .rd_sel_cfg  (rd_sel_cfg),
    .rd_idx      (rd_idx),
    .rd_data     (rd_data),
    .cfg_q       (cfg_q),
    .addr_q      (addr_q)
  );

  pmp_checker i_checker (
    .clock     (clock),
    .reset     (reset),
    .chk_valid (chk_valid),
    .chk_addr  (chk_addr),
    .chk_priv  (chk_priv),
    .chk_kind  (chk_kind),
    .cfg_q     (cfg_q),
    .addr_q    (addr_q),
    .rsp_valid (rsp_valid),
    .rsp_fault (rsp_fault)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log" build.log

verilator --binary --timing -Wno-fatal --top-module pmp_tb -f vlog.f -o pmp_sim \
  > build.log 2>&1 \
  && ./obj_dir/pmp_sim > "$log" 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and $log"; exit 1; }

grep -q "TESTBENCH FAILED" "$log" \
  && { echo "Simulation reported errors, see $log"; exit 1; }

grep -q "TESTBENCH PASSED" "$log" \
  || { echo "No pass line found in $log"; exit 1; }

echo "Simulation passed"
exit 0

//--- sim/pmp_tb.sv
`timescale 1ns/100ps
`include "pmp_macros.svh"

module pmp_tb
  import pmp_pkg::*;
();

  localparam int apb_timeout = 8;

  logic                   clock = 1'b0;
  logic                   reset;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`PMP_CSR_AW-1:0] paddr;
  logic [`PMP_XLEN-1:0]   pwdata;
  logic [`PMP_XLEN-1:0]   prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   chk_valid;
  logic [`PMP_XLEN-1:0]   chk_addr;
  priv_t                  chk_priv;
  access_t                chk_kind;
  logic                   rsp_valid;
  logic                   rsp_fault;

  integer seed;
  int     check_count;
  int     error_count;
  int     timeout_count;

  logic [7:0]           shadow_cfg [0:`PMP_REGIONS-1];
  logic [`PMP_XLEN-1:0] shadow_addr [0:`PMP_REGIONS-1];

  logic                 pending_valid;
  logic                 pending_fault;
  logic [`PMP_XLEN-1:0] pending_addr;

  pmp_top i_dut (.*);

  always #20 clock = ~clock;

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic logic csr_is_cfg(input logic [11:0] a);
    return a >= `PMP_CFG_BASE && a < `PMP_CFG_BASE + `PMP_CFG_WORDS;
  endfunction

  function automatic logic csr_is_addr(input logic [11:0] a);
    return a >= `PMP_ADDR_BASE && a < `PMP_ADDR_BASE + `PMP_REGIONS;
  endfunction

  // Shadow update with the lock rules of the register file
  function automatic void model_write(input logic [11:0] a, input logic [31:0] d);
    int   idx;
    logic frozen;
    if (csr_is_cfg(a)) begin
      idx = int'(a) - int'(`PMP_CFG_BASE);
      for (int b = 0; b < 4; b++) begin
        if (!shadow_cfg[4*idx+b][7]) begin
          shadow_cfg[4*idx+b] = d[8*b +: 8] & 8'h9f;
        end
      end
    end else if (csr_is_addr(a)) begin
      idx    = int'(a) - int'(`PMP_ADDR_BASE);
      frozen = shadow_cfg[idx][7];
      if (idx < `PMP_REGIONS - 1) begin
        frozen = frozen | (shadow_cfg[idx+1][7] && shadow_cfg[idx+1][4:3] == 2'b01);
      end
      if (!frozen) begin
        shadow_addr[idx] = d;
      end
    end
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    int idx;
    if (csr_is_cfg(a)) begin
      idx = 4 * (int'(a) - int'(`PMP_CFG_BASE));
      return {shadow_cfg[idx+3], shadow_cfg[idx+2], shadow_cfg[idx+1], shadow_cfg[idx]};
    end else if (csr_is_addr(a)) begin
      return shadow_addr[int'(a) - int'(`PMP_ADDR_BASE)];
    end
    return 32'd0;
  endfunction

  // Expected verdict from byte ranges built out of the shadow registers
  function automatic logic expected_fault(input logic [31:0] a, input priv_t p,
                                          input access_t k);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] size;
    int          ones;
    logic        perm;
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      lo = 64'd0;
      hi = 64'd0;
      case (shadow_cfg[i][4:3])
        2'b01: begin
          if (i > 0) begin
            lo = {30'd0, shadow_addr[i-1], 2'b00};
          end
          hi = {30'd0, shadow_addr[i], 2'b00};
        end
        2'b10: begin
          lo = {30'd0, shadow_addr[i], 2'b00};
          hi = lo + 64'd4;
        end
        2'b11: begin
          ones = 0;
          while (ones < 32 && shadow_addr[i][ones]) begin
            ones++;
          end
          size = 64'd8 << ones;  // Smallest NAPOT range is eight bytes
          lo   = {30'd0, shadow_addr[i], 2'b00} & ~(size - 64'd1);
          hi   = lo + size;
        end
        default: ;
      endcase
      if ({32'd0, a} >= lo && {32'd0, a} < hi) begin
        case (k)
          exec:    perm = shadow_cfg[i][2];
          read:    perm = shadow_cfg[i][0];
          write:   perm = shadow_cfg[i][1];
          default: perm = 1'b0;
        endcase
        return !(perm || (p == machine && !shadow_cfg[i][7]));
      end
    end
    return p == user;
  endfunction

  task automatic wait_ready(input logic [11:0] a);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!pready && waited < apb_timeout) begin
      @(negedge clock);
      waited++;
    end
    if (!pready) begin
      timeout_count++;
      $display("APB transfer to CSR %h got no pready within %0d cycles", a, apb_timeout);
    end
  endtask

  task automatic write_csr(input logic [11:0] a, input logic [31:0] d);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge clock);
    penable <= 1'b1;
    wait_ready(a);
    @(posedge clock);  // This edge commits the write
    psel    <= 1'b0;
    penable <= 1'b0;
    model_write(a, d);
  endtask

  task automatic read_csr(input logic [11:0] a, output logic [31:0] data, output logic err);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge clock);
    penable <= 1'b1;
    wait_ready(a);
    data = prdata;
    err  = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_csr(input logic [11:0] a);
    logic [31:0] data;
    logic        err;
    read_csr(a, data, err);
    compare_value(data, model_read(a), $sformatf("read data of CSR %h", a));
    compare_value(32'(err), 32'(!(csr_is_cfg(a) || csr_is_addr(a))),
                  $sformatf("pslverr of CSR %h", a));
  endtask

  task automatic check_all_csrs();
    for (int w = 0; w < `PMP_CFG_WORDS; w++) begin
      check_csr(12'(`PMP_CFG_BASE + w));
    end
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      check_csr(12'(`PMP_ADDR_BASE + i));
    end
  endtask

  task automatic issue_check(input logic [31:0] a, input priv_t p, input access_t k);
    @(posedge clock);
    chk_valid <= 1'b1;
    chk_addr  <= a;
    chk_priv  <= p;
    chk_kind  <= k;
  endtask

  task automatic end_checks();
    @(posedge clock);
    chk_valid <= 1'b0;
  endtask

  // Every privilege and kind at one address, back to back
  task automatic probe(input logic [31:0] a);
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 3; k++) begin
        issue_check(a, priv_t'(p), access_t'(k));
      end
    end
    end_checks();
  endtask

  task automatic probe_edges(input logic [31:0] first, input logic [31:0] last);
    probe(first - 32'd1);
    probe(first);
    probe(last);
    probe(last + 32'd1);
  endtask

  task automatic random_checks(input int count);
    logic [31:0] rnd;
    for (int n = 0; n < count; n++) begin
      rnd = $random(seed);
      issue_check({$random(seed)} % 32'h2400, priv_t'(rnd[0]), access_t'(rnd[9:8] % 3));
    end
    end_checks();
  endtask

  task automatic apply_reset();
    reset <= 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      shadow_cfg[i]  = 8'd0;
      shadow_addr[i] = 32'd0;
    end
  endtask

  // A verdict must show up exactly one cycle after its request
  always @(negedge clock) begin
    compare_value(32'(pready), 32'(psel && penable), "pready");
    compare_value(32'(rsp_valid), 32'(pending_valid), "rsp_valid");
    if (pending_valid) begin
      compare_value(32'(rsp_fault), 32'(pending_fault),
                    $sformatf("rsp_fault for address %h", pending_addr));
    end
    pending_valid = chk_valid && reset;
    pending_fault = expected_fault(chk_addr, chk_priv, chk_kind);
    pending_addr  = chk_addr;
  end

  initial begin
    logic [31:0] mask;
    reset         = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    chk_valid     = 1'b0;
    chk_addr      = '0;
    chk_priv      = user;
    chk_kind      = exec;
    pending_valid = 1'b0;
    seed          = 32'heada_2cd4;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    apply_reset();

    check_all_csrs();
    probe(32'h0000_1234);

    write_csr(`PMP_CFG_BASE, 32'h7f6b_3560);  // Reserved bits set, no lock
    write_csr(`PMP_CFG_BASE + 1, 32'h1e0d_7c65);
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      write_csr(12'(`PMP_ADDR_BASE + i), $random(seed));
    end
    check_all_csrs();
    check_csr(12'h3a2);
    check_csr(12'h3b8);
    check_csr(12'h000);
    write_csr(`PMP_CFG_BASE, 32'd0);
    write_csr(`PMP_CFG_BASE + 1, 32'd0);

    // TOR 0x1000..0x1fff read, NA4 0x3000 exec, NAPOT 0x4000..0x40ff read and write
    write_csr(`PMP_ADDR_BASE, 32'h0000_0400);
    write_csr(`PMP_ADDR_BASE + 1, 32'h0000_0800);
    write_csr(`PMP_ADDR_BASE + 2, 32'h0000_0c00);
    write_csr(`PMP_ADDR_BASE + 3, 32'h0000_101f);
    write_csr(`PMP_CFG_BASE, 32'h1b14_0900);
    probe_edges(32'h0000_1000, 32'h0000_1fff);
    probe_edges(32'h0000_3000, 32'h0000_3003);
    probe_edges(32'h0000_4000, 32'h0000_40ff);

    // Region 4 covers 0x4000..0x4fff with exec only, below region 3 in priority
    write_csr(`PMP_ADDR_BASE + 4, 32'h0000_11ff);
    write_csr(`PMP_CFG_BASE + 1, 32'h0000_001c);
    probe(32'h0000_4080);
    probe_edges(32'h0000_4100, 32'h0000_4fff);

    write_csr(`PMP_CFG_BASE, 32'h1b94_8900);  // Lock TOR region 1 and NA4 region 2
    write_csr(`PMP_CFG_BASE, 32'h001f_0f00);
    for (int i = 0; i < 4; i++) begin
      write_csr(12'(`PMP_ADDR_BASE + i), 32'h0000_0123 + i);
    end
    check_all_csrs();
    probe_edges(32'h0000_1000, 32'h0000_1fff);
    probe_edges(32'h0000_3000, 32'h0000_3003);

    apply_reset();
    for (int round = 0; round < 16; round++) begin
      mask = (round >= 14) ? 32'hffff_ffff : 32'h7f7f_7f7f;
      write_csr(`PMP_CFG_BASE, $random(seed) & mask);
      write_csr(`PMP_CFG_BASE + 1, $random(seed) & mask);
      for (int i = 0; i < `PMP_REGIONS; i++) begin
        write_csr(12'(`PMP_ADDR_BASE + i), {$random(seed)} % 32'h800);
      end
      random_checks(64);
    end

    repeat (2) @(posedge clock);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
             timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/pmp_pkg.sv
design/pmp_apb_csr.sv
design/pmp_region_file.sv
design/pmp_checker.sv
design/pmp_top.sv
sim/pmp_tb.sv
